/* hdl/rv_core_settings.svh */
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// ----------------------------------------------------------
// core sizing
// ----------------------------------------------------------

`define RV_XLEN       32             // data and address width
`define RV_REG_COUNT  32             // architectural registers x0..x31

// ----------------------------------------------------------
// boot
// ----------------------------------------------------------

`define RV_RESET_PC   32'h0000_0000  // first fetch address

`endif

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

   // ----------------------------------------------------------
   // major opcodes, inst[6:0]
   // ----------------------------------------------------------

   typedef enum logic [6:0]
   {
      OP_IMM = 7'b0010011,     // register-immediate group
      OP     = 7'b0110011,     // register-register group
      LUI    = 7'b0110111      // load upper immediate
   } opcode_e;

   // funct7 patterns of the base ISA
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA/SRAI

   // ----------------------------------------------------------
   // ALU operations
   // ----------------------------------------------------------

   typedef enum logic [3:0]
   {
      NOP  = 4'd0,             // result is zero
      ADD  = 4'd1,
      SUB  = 4'd2,
      SLL  = 4'd3,
      SLT  = 4'd4,             // signed compare
      SLTU = 4'd5,             // unsigned compare
      XOR  = 4'd6,
      SRL  = 4'd7,
      SRA  = 4'd8,             // fills with sign bit
      OR   = 4'd9,
      AND  = 4'd10
   } alu_op_e;

endpackage

/* hdl/rv_pipe_pkg.sv */
`include "rv_core_settings.svh"

package rv_pipe_pkg;

   typedef logic [`RV_XLEN-1:0]               word_t;
   typedef logic [$clog2(`RV_REG_COUNT)-1:0]  reg_addr_t;

   // fetch -> decode
   typedef struct packed
   {
      logic   valid;
      word_t  pc;
      word_t  inst;
   } if_id_t;

   // decode -> execute, operands already resolved
   typedef struct packed
   {
      logic                 valid;
      logic                 illegal;
      rv_isa_pkg::alu_op_e  alu_op;
      word_t                op1;
      word_t                op2;
      reg_addr_t            rd;
      logic                 we;
   } id_ex_t;

   // execute result, forwarding source and retire record
   typedef struct packed
   {
      logic       valid;
      logic       illegal;
      logic       we;
      reg_addr_t  rd;
      word_t      data;
   } wb_t;

endpackage

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_fetch
(
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  rv_pipe_pkg::word_t   inst_i,
   output rv_pipe_pkg::word_t   inst_addr_o,
   output logic                 inst_ce_o,
   output rv_pipe_pkg::if_id_t  if_id_o
);

   rv_pipe_pkg::word_t   pc_q;
   logic                 ce_q;
   rv_pipe_pkg::if_id_t  if_id_q;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         pc_q    <= `RV_RESET_PC;
         ce_q    <= 1'b0;
         if_id_q <= '0;
      end
      else
      begin
         ce_q <= 1'b1;                       // first cycle out of reset
         if (ce_q)
            pc_q <= pc_q + rv_pipe_pkg::word_t'(4);
         if_id_q.valid <= ce_q;
         if_id_q.pc    <= pc_q;
         if_id_q.inst  <= ce_q ? inst_i : '0; // memory not sampled when idle
      end
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;
   assign if_id_o     = if_id_q;

   // straight-line fetch, no redirects exist
   a_pc_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ce_q |=> (pc_q == $past(pc_q) + rv_pipe_pkg::word_t'(4)))
      else $error("Error: pc did not advance by 4 at %0t", $time);

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_decode
(
   input  rv_pipe_pkg::if_id_t      if_id_i,
   output rv_pipe_pkg::reg_addr_t   rs1_addr_o,
   output rv_pipe_pkg::reg_addr_t   rs2_addr_o,
   input  rv_pipe_pkg::word_t       rs1_data_i,
   input  rv_pipe_pkg::word_t       rs2_data_i,
   input  rv_pipe_pkg::wb_t         ex_fwd_i,
   input  rv_pipe_pkg::wb_t         wb_i,
   output rv_pipe_pkg::id_ex_t      id_ex_o
);

   rv_isa_pkg::opcode_e     opcode;
   logic [2:0]              funct3;
   logic [6:0]              funct7;
   rv_pipe_pkg::reg_addr_t  rd;
   rv_isa_pkg::alu_op_e     alu_op;
   logic                    read_rs1;
   logic                    read_rs2;
   logic                    illegal;
   rv_pipe_pkg::word_t      imm;
   rv_pipe_pkg::word_t      imm_i;
   rv_pipe_pkg::word_t      imm_sh;
   rv_pipe_pkg::word_t      imm_u;

   // youngest producer wins, then write-back, then the register file
   function automatic rv_pipe_pkg::word_t fwd_operand
   (
      input logic                    read,
      input rv_pipe_pkg::reg_addr_t  addr,
      input rv_pipe_pkg::word_t      rf_data,
      input rv_pipe_pkg::word_t      alt,
      input rv_pipe_pkg::wb_t        ex_fwd,
      input rv_pipe_pkg::wb_t        wb
   );
      if (!read)
         return alt;
      if (ex_fwd.we && ex_fwd.rd == addr)
         return ex_fwd.data;
      if (wb.we && wb.rd == addr)
         return wb.data;
      return rf_data;
   endfunction

   // ----------------------------------------------------------
   // field extraction
   // ----------------------------------------------------------

   assign opcode     = rv_isa_pkg::opcode_e'(if_id_i.inst[6:0]);
   assign rd         = if_id_i.inst[11:7];
   assign funct3     = if_id_i.inst[14:12];
   assign funct7     = if_id_i.inst[31:25];
   assign rs1_addr_o = if_id_i.inst[19:15];
   assign rs2_addr_o = if_id_i.inst[24:20];

   assign imm_i  = {{(`RV_XLEN-12){if_id_i.inst[31]}}, if_id_i.inst[31:20]}; // sign-extended
   assign imm_sh = {{(`RV_XLEN-5){1'b0}}, if_id_i.inst[24:20]};
   assign imm_u  = {if_id_i.inst[31:12], 12'h000};

   // ----------------------------------------------------------
   // opcode decode
   // ----------------------------------------------------------

   always_comb
   begin
      alu_op   = rv_isa_pkg::NOP;
      read_rs1 = 1'b0;
      read_rs2 = 1'b0;
      imm      = '0;
      illegal  = 1'b0;
      case (opcode)
         rv_isa_pkg::OP_IMM:
         begin
            read_rs1 = 1'b1;
            imm      = imm_i;
            case (funct3)
               3'b000: alu_op = rv_isa_pkg::ADD;
               3'b010: alu_op = rv_isa_pkg::SLT;
               3'b011: alu_op = rv_isa_pkg::SLTU;
               3'b100: alu_op = rv_isa_pkg::XOR;
               3'b110: alu_op = rv_isa_pkg::OR;
               3'b111: alu_op = rv_isa_pkg::AND;
               3'b001:
               begin
                  imm     = imm_sh;
                  alu_op  = rv_isa_pkg::SLL;
                  illegal = (funct7 != rv_isa_pkg::F7_BASE);
               end
               default:                     // 3'b101, SRLI or SRAI
               begin
                  imm = imm_sh;
                  if (funct7 == rv_isa_pkg::F7_BASE)
                     alu_op = rv_isa_pkg::SRL;
                  else if (funct7 == rv_isa_pkg::F7_ALT)
                     alu_op = rv_isa_pkg::SRA;
                  else
                     illegal = 1'b1;
               end
            endcase
         end
         rv_isa_pkg::OP:
         begin
            read_rs1 = 1'b1;
            read_rs2 = 1'b1;
            case ({funct7, funct3})
               {rv_isa_pkg::F7_BASE, 3'b000}: alu_op = rv_isa_pkg::ADD;
               {rv_isa_pkg::F7_ALT,  3'b000}: alu_op = rv_isa_pkg::SUB;
               {rv_isa_pkg::F7_BASE, 3'b001}: alu_op = rv_isa_pkg::SLL;
               {rv_isa_pkg::F7_BASE, 3'b010}: alu_op = rv_isa_pkg::SLT;
               {rv_isa_pkg::F7_BASE, 3'b011}: alu_op = rv_isa_pkg::SLTU;
               {rv_isa_pkg::F7_BASE, 3'b100}: alu_op = rv_isa_pkg::XOR;
               {rv_isa_pkg::F7_BASE, 3'b101}: alu_op = rv_isa_pkg::SRL;
               {rv_isa_pkg::F7_ALT,  3'b101}: alu_op = rv_isa_pkg::SRA;
               {rv_isa_pkg::F7_BASE, 3'b110}: alu_op = rv_isa_pkg::OR;
               {rv_isa_pkg::F7_BASE, 3'b111}: alu_op = rv_isa_pkg::AND;
               default: illegal = 1'b1;
            endcase
         end
         rv_isa_pkg::LUI:
         begin
            alu_op = rv_isa_pkg::ADD;       // 0 + upper immediate
            imm    = imm_u;
         end
         default: illegal = 1'b1;
      endcase
      if (illegal)
         alu_op = rv_isa_pkg::NOP;
   end

   // ----------------------------------------------------------
   // operands and control to execute
   // ----------------------------------------------------------

   always_comb
   begin
      id_ex_o.valid   = if_id_i.valid;
      id_ex_o.illegal = if_id_i.valid & illegal;
      id_ex_o.alu_op  = alu_op;
      id_ex_o.op1     = fwd_operand(read_rs1, rs1_addr_o, rs1_data_i, '0, ex_fwd_i, wb_i);
      id_ex_o.op2     = fwd_operand(read_rs2, rs2_addr_o, rs2_data_i, imm, ex_fwd_i, wb_i);
      id_ex_o.rd      = rd;
      id_ex_o.we      = if_id_i.valid & ~illegal & (rd != '0); // x0 never written
   end

   always_comb
   begin
      if (id_ex_o.valid)
         a_illegal_no_we: assert (!(id_ex_o.illegal && id_ex_o.we))
            else $error("Error: illegal instruction carries write enable at %0t", $time);
   end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_regfile
(
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  rv_pipe_pkg::reg_addr_t  rs1_addr_i,
   input  rv_pipe_pkg::reg_addr_t  rs2_addr_i,
   output rv_pipe_pkg::word_t      rs1_data_o,
   output rv_pipe_pkg::word_t      rs2_data_o,
   input  rv_pipe_pkg::wb_t        wb_i
);

   rv_pipe_pkg::word_t regs_q [`RV_REG_COUNT];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         regs_q <= '{default: '0};
      else if (wb_i.valid && wb_i.we && wb_i.rd != '0)  // x0 stays zero
         regs_q[wb_i.rd] <= wb_i.data;
   end

   assign rs1_data_o = regs_q[rs1_addr_i];  // no bypass, decode forwards
   assign rs2_data_o = regs_q[rs2_addr_i];

   // x0 held at zero by the write guard alone
   a_x0_rs1: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rs1_addr_i == '0) |-> (rs1_data_o == '0))
      else $error("Error: x0 read nonzero on port 1 at %0t", $time);

   a_x0_rs2: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rs2_addr_i == '0) |-> (rs2_data_o == '0))
      else $error("Error: x0 read nonzero on port 2 at %0t", $time);

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_execute
(
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  rv_pipe_pkg::id_ex_t  id_ex_i,
   output rv_pipe_pkg::wb_t     ex_fwd_o,
   output rv_pipe_pkg::wb_t     wb_o
);

   rv_pipe_pkg::id_ex_t          ex_q;
   rv_pipe_pkg::wb_t             wb_q;
   rv_pipe_pkg::word_t           alu_result;
   logic [$clog2(`RV_XLEN)-1:0]  shamt;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ex_q <= '0;
         wb_q <= '0;
      end
      else
      begin
         ex_q <= id_ex_i;
         wb_q <= ex_fwd_o;
      end
   end

   // ----------------------------------------------------------
   // ALU
   // ----------------------------------------------------------

   assign shamt = ex_q.op2[$clog2(`RV_XLEN)-1:0];   // low 5 bits only

   always_comb
   begin
      case (ex_q.alu_op)
         rv_isa_pkg::ADD:  alu_result = ex_q.op1 + ex_q.op2;
         rv_isa_pkg::SUB:  alu_result = ex_q.op1 - ex_q.op2;
         rv_isa_pkg::SLL:  alu_result = ex_q.op1 << shamt;
         rv_isa_pkg::SLT:  alu_result = rv_pipe_pkg::word_t'($signed(ex_q.op1) < $signed(ex_q.op2));
         rv_isa_pkg::SLTU: alu_result = rv_pipe_pkg::word_t'(ex_q.op1 < ex_q.op2);
         rv_isa_pkg::XOR:  alu_result = ex_q.op1 ^ ex_q.op2;
         rv_isa_pkg::SRL:  alu_result = ex_q.op1 >> shamt;
         rv_isa_pkg::SRA:  alu_result = rv_pipe_pkg::word_t'($signed(ex_q.op1) >>> shamt);
         rv_isa_pkg::OR:   alu_result = ex_q.op1 | ex_q.op2;
         rv_isa_pkg::AND:  alu_result = ex_q.op1 & ex_q.op2;
         default:          alu_result = '0;       // NOP and illegal
      endcase
   end

   assign ex_fwd_o = '{valid:   ex_q.valid,
                       illegal: ex_q.illegal,
                       we:      ex_q.we,
                       rd:      ex_q.rd,
                       data:    alu_result};

   assign wb_o = wb_q;  // retire record, also regfile write port

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   output rv_pipe_pkg::word_t  inst_addr_o,
   output logic                inst_ce_o,
   input  rv_pipe_pkg::word_t  inst_i,
   output rv_pipe_pkg::wb_t    retire_o
);

   rv_pipe_pkg::if_id_t     if_id;
   rv_pipe_pkg::id_ex_t     id_ex;
   rv_pipe_pkg::wb_t        ex_fwd;     // result in execute this cycle
   rv_pipe_pkg::wb_t        wb;         // result in write-back
   rv_pipe_pkg::reg_addr_t  rs1_addr;
   rv_pipe_pkg::reg_addr_t  rs2_addr;
   rv_pipe_pkg::word_t      rs1_data;
   rv_pipe_pkg::word_t      rs2_data;

   rv_fetch i_fetch
   (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .if_id_o     (if_id)
   );

   rv_decode i_decode
   (
      .if_id_i    (if_id),
      .rs1_addr_o (rs1_addr),
      .rs2_addr_o (rs2_addr),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .ex_fwd_i   (ex_fwd),
      .wb_i       (wb),
      .id_ex_o    (id_ex)
   );

   rv_regfile i_regfile
   (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wb_i       (wb)
   );

   rv_execute i_execute
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .id_ex_i  (id_ex),
      .ex_fwd_o (ex_fwd),
      .wb_o     (wb)
   );

   assign retire_o = wb;

endmodule

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_tb;

   localparam int PROG_LEN       = 128;            // one program word per memory entry
   localparam int TIMEOUT_CYCLES = PROG_LEN + 64;

   logic                 clk;
   logic                 arst_n;
   rv_pipe_pkg::word_t   inst;
   rv_pipe_pkg::word_t   inst_addr;
   logic                 inst_ce;
   rv_pipe_pkg::wb_t     retire;

   rv_pipe_pkg::word_t   prog_mem   [PROG_LEN];
   rv_pipe_pkg::wb_t     exp_rec    [PROG_LEN];  // expected retire stream
   rv_pipe_pkg::word_t   model_regs [`RV_REG_COUNT];
   int                   prog_count    = 0;
   int                   fetch_count   = 0;
   int                   ret_idx       = 0;
   int                   error_count   = 0;
   int                   timeout_count = 0;

   rv_core_top i_dut
   (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .inst_addr_o (inst_addr),
      .inst_ce_o   (inst_ce),
      .inst_i      (inst),
      .retire_o    (retire)
   );

   assign inst = prog_mem[inst_addr[$clog2(PROG_LEN)+1:2]];  // zero-wait fetch port

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ----------------------------------------------------------
   // encoders and reference model
   // ----------------------------------------------------------

   function automatic rv_pipe_pkg::word_t imm_inst(input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
   endfunction

   function automatic rv_pipe_pkg::word_t reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                                   input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
   endfunction

   function automatic rv_pipe_pkg::word_t lui_inst(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, rv_isa_pkg::LUI};
   endfunction

   // stores the word and runs it through the register model in program order
   task automatic append_inst(input rv_pipe_pkg::word_t inst_w);
      logic [6:0]          opc;
      logic [6:0]          f7;
      logic [2:0]          f3;
      rv_pipe_pkg::word_t  a;
      rv_pipe_pkg::word_t  b;
      rv_pipe_pkg::word_t  res;
      logic                bad;
      opc = inst_w[6:0];
      f7  = inst_w[31:25];
      f3  = inst_w[14:12];
      a   = model_regs[inst_w[19:15]];
      if (opc == rv_isa_pkg::OP)
         b = model_regs[inst_w[24:20]];
      else
         b = {{20{inst_w[31]}}, inst_w[31:20]};      // sign-extended I immediate
      res = '0;
      bad = (opc == rv_isa_pkg::OP || f3 == 3'd1 || f3 == 3'd5) &&
            !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd5 || (opc == rv_isa_pkg::OP && f3 == 3'd0))));
      if (opc == rv_isa_pkg::LUI)
      begin
         bad = 1'b0;
         res = {inst_w[31:12], 12'h000};
      end
      else if (opc != rv_isa_pkg::OP_IMM && opc != rv_isa_pkg::OP)
         bad = 1'b1;
      else
      begin
         case (f3)
            3'd0: res = (opc == rv_isa_pkg::OP && f7[5]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5:
            begin
               if (f7[5])
                  res = $signed(a) >>> b[4:0];
               else
                  res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
         endcase
      end
      exp_rec[prog_count] = '{valid: 1'b1, illegal: bad, we: !bad && inst_w[11:7] != 5'd0,
                              rd: inst_w[11:7], data: res};
      if (exp_rec[prog_count].we)
         model_regs[inst_w[11:7]] = res;
      prog_mem[prog_count] = inst_w;
      prog_count++;
   endtask

   task automatic build_program;
      rv_pipe_pkg::word_t  r;
      rv_pipe_pkg::word_t  s;
      logic [2:0]          f3;
      logic [11:0]         imm;
      foreach (model_regs[i])
         model_regs[i] = '0;
      // producer with consumers 1, 2 and 3 slots later
      append_inst(imm_inst(3'd0, 5'd1, 5'd0, 12'hffb));                    // addi x1, x0, -5
      append_inst(imm_inst(3'd0, 5'd2, 5'd1, 12'h007));                    // from execute
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd0, 5'd3, 5'd1, 5'd1));  // from write-back
      append_inst(reg_inst(rv_isa_pkg::F7_ALT, 3'd0, 5'd4, 5'd0, 5'd1));   // from regfile
      append_inst(lui_inst(5'd5, 20'h80000));
      append_inst(imm_inst(3'd5, 5'd6, 5'd5, 12'h41f));                    // srai by 31
      append_inst(imm_inst(3'd5, 5'd7, 5'd5, 12'h01f));                    // srli by 31
      append_inst(imm_inst(3'd1, 5'd6, 5'd7, 12'h000));                    // slli by 0
      append_inst(imm_inst(3'd1, 5'd7, 5'd7, 12'h01f));                    // slli by 31
      append_inst(imm_inst(3'd0, 5'd7, 5'd0, 12'h004));
      append_inst(reg_inst(rv_isa_pkg::F7_ALT, 3'd5, 5'd6, 5'd5, 5'd7));   // sra negative
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd5, 5'd6, 5'd5, 5'd7));  // srl negative
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd1, 5'd6, 5'd6, 5'd7));
      append_inst(reg_inst(rv_isa_pkg::F7_ALT, 3'd0, 5'd1, 5'd0, 5'd7));   // 0 - 4 borrows
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd2, 5'd2, 5'd1, 5'd0));
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd3, 5'd2, 5'd1, 5'd0));
      append_inst(imm_inst(3'd2, 5'd3, 5'd1, 12'hfff));                    // slti -1
      append_inst(imm_inst(3'd3, 5'd3, 5'd0, 12'hfff));                    // sltiu all ones
      append_inst(imm_inst(3'd4, 5'd4, 5'd5, 12'hfff));
      append_inst(imm_inst(3'd6, 5'd4, 5'd4, 12'h800));
      append_inst(imm_inst(3'd7, 5'd4, 5'd4, 12'h8f0));
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd4, 5'd4, 5'd4, 5'd1));
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd6, 5'd4, 5'd4, 5'd6));
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd7, 5'd4, 5'd4, 5'd1));
      append_inst(imm_inst(3'd0, 5'd0, 5'd1, 12'h001));                    // write to x0
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd0, 5'd2, 5'd0, 5'd0)); // x0 reads zero
      append_inst(32'h0000_0000);
      append_inst(reg_inst(7'h01, 3'd0, 5'd3, 5'd1, 5'd2));                // mul, not in RV32I
      append_inst(imm_inst(3'd1, 5'd3, 5'd1, 12'h41f));                    // slli, bad funct7
      append_inst(32'hffff_ffff);
      append_inst(reg_inst(rv_isa_pkg::F7_BASE, 3'd0, 5'd3, 5'd3, 5'd0));
      while (prog_count < PROG_LEN)
      begin
         r  = $urandom;
         s  = $urandom;
         f3 = r[12:10];
         if (r[9:5] == 5'd0)
            append_inst({s[31:7], 7'b0001011});     // custom-0, never decoded
         else if (r[1:0] == 2'd0)
            append_inst(lui_inst({2'b00, r[4:2]}, s[31:12]));
         else if (r[1:0] == 2'd1)
            append_inst(reg_inst((r[13] && (f3 == 3'd0 || f3 == 3'd5)) ? rv_isa_pkg::F7_ALT :
                                 rv_isa_pkg::F7_BASE, f3, {2'b00, r[4:2]}, {2'b00, r[16:14]},
                                 {2'b00, r[19:17]}));
         else
         begin
            imm = s[11:0];
            if (f3 == 3'd1)
               imm[11:5] = rv_isa_pkg::F7_BASE;
            else if (f3 == 3'd5)
               imm[11:5] = r[13] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
            append_inst(imm_inst(f3, {2'b00, r[4:2]}, {2'b00, r[16:14]}, imm));
         end
      end
   endtask

   function automatic logic record_matches(input rv_pipe_pkg::wb_t got,
                                           input rv_pipe_pkg::wb_t want);
      if (got.valid !== want.valid || got.illegal !== want.illegal || got.we !== want.we)
         return 1'b0;
      if (want.illegal)
         return 1'b1;                               // data of an illegal retire is undefined
      return got.rd === want.rd && got.data === want.data;
   endfunction

   // ----------------------------------------------------------
   // progress counters and checks
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         fetch_count <= 0;
         ret_idx     <= 0;
      end
      else
      begin
         if (inst_ce)
            fetch_count <= fetch_count + 1;
         if (retire.valid)
            ret_idx <= ret_idx + 1;
      end
   end

   a_reset_state: assert property (@(posedge clk)
      !arst_n |-> (!inst_ce && inst_addr == `RV_RESET_PC && !retire.valid && !retire.we))
      else
      begin
         error_count++;
         $display("Error: %0t fetch or retire port active, or pc off reset value in reset",
                  $time);
      end

   // fetch starts in the first cycle after reset release
   a_ce_rise: assert property (@(posedge clk)
      $rose(arst_n) |=> (inst_ce && !$past(inst_ce)))
      else
      begin
         error_count++;
         $display("Error: %0t fetch enable did not rise one cycle after reset release", $time);
      end

   a_fetch_addr: assert property (@(posedge clk) disable iff (!arst_n)
      inst_ce |-> (inst_addr == `RV_RESET_PC + 4 * fetch_count))
      else
      begin
         error_count++;
         $display("Error: %0t fetch address %h out of sequence", $time, $sampled(inst_addr));
      end

   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      retire.valid |-> (fetch_count == ret_idx + 3))
      else
      begin
         error_count++;
         $display("Error: %0t retire not 3 cycles after its fetch", $time);
      end

   a_no_bubble: assert property (@(posedge clk) disable iff (!arst_n)
      (fetch_count >= 3) |-> retire.valid)
      else
      begin
         error_count++;
         $display("Error: %0t bubble on the retire port", $time);
      end

   a_retire_record: assert property (@(posedge clk) disable iff (!arst_n)
      (retire.valid && ret_idx < PROG_LEN) |-> record_matches(retire, exp_rec[ret_idx]))
      else
      begin
         error_count++;
         $display("Error: %0t retire %0d differs from the register model", $time,
                  $sampled(ret_idx));
      end

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------

   initial
   begin
      int cycles;
      arst_n = 1'b1;
      void'($urandom(83673));
      build_program();
      #2 arst_n = 1'b0;
      repeat (16) @(posedge clk);
      #1 arst_n = 1'b1;
      cycles = 0;
      while (ret_idx < PROG_LEN && cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         #1 cycles++;
      end
      if (ret_idx < PROG_LEN)
      begin
         timeout_count++;
         $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
                  ret_idx, PROG_LEN, TIMEOUT_CYCLES);
      end
      $display("Check errors: %0d, timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
bench/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
   --top-module rv_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vrv_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
